/* sources.f */
common/rrag_pkg.sv
common/wb_if.sv
regfile/regfile.sv
segfile/segfile.sv
design/issue_ctrl.sv
design/agen.sv
design/rrag.sv
testbench/rrag_props.sv
testbench/rrag_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := rrag_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
SIM_ARGS  := +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/rrag_tb.sv */
`timescale 1ns/10ps

module rrag_tb import rrag_pkg::*; ();

    localparam int RAND_CYCLES = 800;
    localparam int MAX_CYCLES  = 2000;

    logic              clk, rst, valid_in, fwd_stall;
    logic              usereg2, usereg3, mem1_use, mem2_use, is_rep, dest_en;
    logic [REG_AW-1:0] reg_addr1, reg_addr2, reg_addr3, reg_addr4;
    logic [REG_AW-1:0] seg_addr1, seg_addr2, dest_reg;
    opsize_t           opsize;
    logic [1:0]        shf_amnt;
    logic [DATA_W-1:0] disp;
    logic              wb_ld, wb_seg_ld;
    logic [REG_AW-1:0] wb_addr, wb_seg_addr;
    logic [DATA_W-1:0] wb_data;
    logic [TAG_W-1:0]  wb_tag;
    logic [SEG_W-1:0]  wb_seg_data;
    logic              valid_out, stall, busy1, busy2, busy3, busy4;
    logic [TAG_W-1:0]  inst_tag;
    logic [DATA_W-1:0] reg1, reg2, reg3, reg4;
    logic [SEG_W-1:0]  seg1, seg2;
    logic [DATA_W-1:0] mem_addr1, mem_addr1_end, mem_addr2, mem_addr2_end, rep_num;
    int                cycles = 0;

    rrag UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (UUT.props.fail_count != 0) begin
            $display("Test failed");
            $fatal(1, "an assertion reported a mismatch");
        end else if (cycles >= MAX_CYCLES) begin
            $display("Test failed");
            $fatal(1, "run did not end within %0d cycles", MAX_CYCLES);
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_inputs();
        valid_in    = 1'b0;
        fwd_stall   = 1'b0;
        reg_addr1   = '0;
        reg_addr2   = '0;
        reg_addr3   = '0;
        reg_addr4   = '0;
        seg_addr1   = '0;
        seg_addr2   = '0;
        opsize      = SZ_DWORD;
        shf_amnt    = '0;
        disp        = '0;
        usereg2     = 1'b0;
        usereg3     = 1'b0;
        mem1_use    = 1'b0;
        mem2_use    = 1'b0;
        is_rep      = 1'b0;
        dest_en     = 1'b0;
        dest_reg    = '0;
        wb_ld       = 1'b0;
        wb_addr     = '0;
        wb_data     = '0;
        wb_tag      = '0;
        wb_seg_ld   = 1'b0;
        wb_seg_addr = '0;
        wb_seg_data = '0;
    endtask

    task automatic randomize_operands();
        reg_addr1 = REG_AW'($urandom);
        reg_addr2 = REG_AW'($urandom);
        reg_addr3 = REG_AW'($urandom);
        reg_addr4 = REG_AW'($urandom);
        seg_addr1 = REG_AW'($urandom);
        seg_addr2 = REG_AW'($urandom);
        opsize    = opsize_t'($urandom_range(0, 3));
        shf_amnt  = 2'($urandom);
        disp      = $urandom;
        usereg2   = 1'($urandom);
        usereg3   = 1'($urandom);
        mem1_use  = 1'($urandom);
        mem2_use  = 1'($urandom);
        is_rep    = 1'($urandom);
    endtask

    initial begin
        logic [TAG_W-1:0] tag_a;
        logic [TAG_W-1:0] tag_b;
        void'($urandom(32'haefefb13));
        idle_inputs();
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // fill every register and segment base
        for (int i = 0; i < NUM_REGS; i++) begin
            randomize_operands();
            wb_ld       = 1'b1;
            wb_addr     = REG_AW'(i);
            wb_data     = 32'h1357_9bdf ^ (32'h0101_0101 * 32'(i + 1));
            wb_seg_ld   = 1'b1;
            wb_seg_addr = REG_AW'(i);
            wb_seg_data = 16'h0f00 ^ 16'(32'h0111 * 32'(i + 1));
            tick();
        end
        idle_inputs();

        for (int n = 0; n < RAND_CYCLES; n++) begin
            randomize_operands();
            valid_in    = ($urandom_range(0, 3) != 0);
            dest_en     = ($urandom_range(0, 1) == 0);
            dest_reg    = REG_AW'($urandom);
            wb_ld       = ($urandom_range(0, 2) == 0);
            wb_addr     = REG_AW'($urandom);
            wb_data     = $urandom;
            // recent tags mostly, older ones leave the mark in place
            wb_tag      = inst_tag - TAG_W'($urandom_range(1, 3));
            wb_seg_ld   = ($urandom_range(0, 7) == 0);
            wb_seg_addr = REG_AW'($urandom);
            wb_seg_data = 16'($urandom);
            tick();
        end
        idle_inputs();

        // two writers of r2, the first tag goes stale
        valid_in = 1'b1;
        dest_en  = 1'b1;
        dest_reg = 3'd2;
        tag_a    = inst_tag;
        tick();
        tag_b = inst_tag;
        tick();
        dest_en   = 1'b0;
        mem1_use  = 1'b1;
        usereg2   = 1'b1;
        reg_addr2 = 3'd2;
        tick();
        wb_ld   = 1'b1;
        wb_addr = 3'd2;
        wb_data = 32'h0bad_0002;
        wb_tag  = tag_a;
        tick();
        wb_tag = tag_b;
        tick();
        wb_ld = 1'b0;
        tick();

        // clear and new mark of r3 on the same edge
        mem1_use = 1'b0;
        usereg2  = 1'b0;
        dest_en  = 1'b1;
        dest_reg = 3'd3;
        tag_a    = inst_tag;
        tick();
        wb_ld   = 1'b1;
        wb_addr = 3'd3;
        wb_tag  = tag_a;
        tag_b   = inst_tag;
        tick();
        wb_ld     = 1'b0;
        dest_en   = 1'b0;
        mem2_use  = 1'b1;
        reg_addr4 = 3'd3;
        tick();
        wb_ld  = 1'b1;
        wb_tag = tag_b;
        tick();
        idle_inputs();
        tick();

        // upstream holds its operands for the whole burst
        for (int b = 0; b < 12; b++) begin
            fwd_stall = 1'b1;
            randomize_operands();
            valid_in = 1'b1;
            dest_en  = 1'b1;
            dest_reg = REG_AW'($urandom);
            repeat ($urandom_range(1, 6)) begin
                tick();
            end
            fwd_stall = 1'b0;
            repeat ($urandom_range(1, 4)) begin
                randomize_operands();
                tick();
            end
        end
        idle_inputs();
        tick();
        tick();

        if (UUT.props.fail_count != 0) begin
            $display("Test failed");
            $fatal(1, "an assertion reported a mismatch");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

/* testbench/rrag_props.sv */
`timescale 1ns/10ps

module rrag_props import rrag_pkg::*; (
    input logic              clk, rst, valid_in, fwd_stall, valid_out, stall,
    input logic              usereg2, usereg3, mem1_use, mem2_use, is_rep, dest_en,
    input logic              wb_ld, wb_seg_ld, busy1, busy2, busy3, busy4,
    input logic [REG_AW-1:0] reg_addr1, reg_addr2, reg_addr3, reg_addr4,
    input logic [REG_AW-1:0] seg_addr1, seg_addr2, dest_reg, wb_addr, wb_seg_addr,
    input opsize_t           opsize,
    input logic [1:0]        shf_amnt,
    input logic [TAG_W-1:0]  wb_tag, inst_tag,
    input logic [SEG_W-1:0]  wb_seg_data, seg1, seg2,
    input logic [DATA_W-1:0] disp, wb_data, reg1, reg2, reg3, reg4,
    input logic [DATA_W-1:0] mem_addr1, mem_addr1_end, mem_addr2, mem_addr2_end, rep_num
);

    logic [DATA_W-1:0]   model_regs [NUM_REGS];
    logic [SEG_W-1:0]    model_segs [NUM_REGS];
    logic [TAG_W-1:0]    model_owner [NUM_REGS];
    logic [NUM_REGS-1:0] model_pend;
    logic [TAG_W-1:0]    model_tag;
    logic [DATA_W-1:0]   exp_mask;
    logic [DATA_W-1:0]   exp_span;
    logic [DATA_W-1:0]   exp_addr1;
    logic [DATA_W-1:0]   exp_addr2;
    logic [4*DATA_W-1:0] exp_regs;
    logic [5*DATA_W-1:0] exp_addr;
    logic                exp_stall;
    logic                exp_issue;
    int                  fail_count = 0;

    always_comb begin
        case (opsize)
            SZ_BYTE: begin
                exp_mask = 32'h0000_00ff;
                exp_span = 32'd0;
            end
            SZ_WORD: begin
                exp_mask = 32'h0000_ffff;
                exp_span = 32'd1;
            end
            default: begin
                exp_mask = 32'hffff_ffff;
                exp_span = 32'd3;
            end
        endcase
    end

    assign exp_stall = fwd_stall
        || (mem1_use && ((usereg2 && model_pend[reg_addr2]) || (usereg3 && model_pend[reg_addr3])))
        || (mem2_use && model_pend[reg_addr4]);
    assign exp_issue = valid_in && !exp_stall;

    assign exp_addr1 = (usereg2 ? model_regs[reg_addr2] : 32'd0)
        + (usereg3 ? (model_regs[reg_addr3] << shf_amnt) : 32'd0)
        + disp + {model_segs[seg_addr1], 16'h0000};
    assign exp_addr2 = model_regs[reg_addr4] + {model_segs[seg_addr2], 16'h0000};

    assign exp_regs = {model_regs[reg_addr1], model_regs[reg_addr2],
                       model_regs[reg_addr3], model_regs[reg_addr4]} & {4{exp_mask}};
    assign exp_addr = {exp_addr1, exp_addr1 + exp_span, exp_addr2, exp_addr2 + exp_span,
                       is_rep ? model_regs[reg_addr4] : 32'd0};

    always_ff @(posedge clk) begin
        if (rst) begin
            model_regs  <= '{default: '0};
            model_segs  <= '{default: '0};
            model_owner <= '{default: '0};
            model_pend  <= '0;
            model_tag   <= '0;
        end else begin
            if (wb_ld) begin
                model_regs[wb_addr] <= wb_data;
            end
            if (wb_seg_ld) begin
                model_segs[wb_seg_addr] <= wb_seg_data;
            end
            if (wb_ld && model_owner[wb_addr] == wb_tag) begin
                model_pend[wb_addr] <= 1'b0;
            end
            // a mark on the same edge wins over the clear
            if (exp_issue && dest_en) begin
                model_pend[dest_reg]  <= 1'b1;
                model_owner[dest_reg] <= model_tag;
                model_tag             <= model_tag + 1'b1;
            end
        end
    end

    a_reset: assert property (@(posedge clk) $fell(rst) |->
        inst_tag == '0 && !stall && !valid_out && {busy1, busy2, busy3, busy4} == 4'b0000)
        else begin
            fail_count++;
            $error("Mismatch after reset: inst_tag %h stall %h valid_out %h busy %h",
                $sampled(inst_tag), $sampled(stall), $sampled(valid_out),
                $sampled({busy1, busy2, busy3, busy4}));
        end

    a_regs: assert property (@(posedge clk) disable iff (rst)
        {reg1, reg2, reg3, reg4} == exp_regs)
        else begin
            fail_count++;
            $error("Mismatch reg1..reg4: got %h expected %h",
                $sampled({reg1, reg2, reg3, reg4}), $sampled(exp_regs));
        end

    a_segs: assert property (@(posedge clk) disable iff (rst)
        {seg1, seg2} == {model_segs[seg_addr1], model_segs[seg_addr2]})
        else begin
            fail_count++;
            $error("Mismatch seg1,seg2: got %h expected %h", $sampled({seg1, seg2}),
                $sampled({model_segs[seg_addr1], model_segs[seg_addr2]}));
        end

    a_addr: assert property (@(posedge clk) disable iff (rst)
        {mem_addr1, mem_addr1_end, mem_addr2, mem_addr2_end, rep_num} == exp_addr)
        else begin
            fail_count++;
            $error("Mismatch mem_addr1,mem_addr1_end,mem_addr2,mem_addr2_end,rep_num: %h vs %h",
                $sampled({mem_addr1, mem_addr1_end, mem_addr2, mem_addr2_end, rep_num}),
                $sampled(exp_addr));
        end

    a_busy: assert property (@(posedge clk) disable iff (rst)
        {busy1, busy2, busy3, busy4} == {model_pend[reg_addr1], model_pend[reg_addr2],
                                         model_pend[reg_addr3], model_pend[reg_addr4]})
        else begin
            fail_count++;
            $error("Mismatch busy1..busy4: got %h expected %h",
                $sampled({busy1, busy2, busy3, busy4}),
                $sampled({model_pend[reg_addr1], model_pend[reg_addr2],
                          model_pend[reg_addr3], model_pend[reg_addr4]}));
        end

    // with the read addresses held, no mark may appear or vanish under fwd_stall
    a_pend_hold: assert property (@(posedge clk) disable iff (rst)
        fwd_stall && !wb_ld |=> !$stable({reg_addr1, reg_addr2, reg_addr3, reg_addr4})
            || $stable({busy1, busy2, busy3, busy4}))
        else begin
            fail_count++;
            $error("Mismatch busy1..busy4 under fwd_stall: got %h for regs %h",
                $sampled({busy1, busy2, busy3, busy4}),
                $sampled({reg_addr1, reg_addr2, reg_addr3, reg_addr4}));
        end

    a_stall: assert property (@(posedge clk) disable iff (rst) stall == exp_stall)
        else begin
            fail_count++;
            $error("Mismatch stall: got %h expected %h", $sampled(stall), $sampled(exp_stall));
        end

    a_valid: assert property (@(posedge clk) disable iff (rst) valid_out == exp_issue)
        else begin
            fail_count++;
            $error("Mismatch valid_out: got %h expected %h", $sampled(valid_out),
                $sampled(exp_issue));
        end

    a_tag_step: assert property (@(posedge clk) disable iff (rst)
        valid_out && dest_en |=> inst_tag == $past(inst_tag) + 1'b1)
        else begin
            fail_count++;
            $error("Mismatch inst_tag: got %h expected %h", $sampled(inst_tag),
                $sampled(model_tag));
        end

    // covers the fwd_stall hold, nothing issues there
    a_tag_hold: assert property (@(posedge clk) disable iff (rst)
        !(valid_out && dest_en) |=> $stable(inst_tag))
        else begin
            fail_count++;
            $error("Mismatch inst_tag: got %h expected %h", $sampled(inst_tag),
                $sampled(model_tag));
        end

endmodule

bind rrag rrag_props props (.*);

/* design/rrag.sv */
`timescale 1ns/10ps

module rrag import rrag_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid_in,
    input  logic                fwd_stall,
    input  logic [REG_AW-1:0]   reg_addr1,
    input  logic [REG_AW-1:0]   reg_addr2,
    input  logic [REG_AW-1:0]   reg_addr3,
    input  logic [REG_AW-1:0]   reg_addr4,
    input  logic [REG_AW-1:0]   seg_addr1,
    input  logic [REG_AW-1:0]   seg_addr2,
    input  opsize_t             opsize,
    input  logic [1:0]          shf_amnt,
    input  logic [DATA_W-1:0]   disp,
    input  logic                usereg2,
    input  logic                usereg3,
    input  logic                mem1_use,
    input  logic                mem2_use,
    input  logic                is_rep,
    input  logic                dest_en,
    input  logic [REG_AW-1:0]   dest_reg,
    input  logic                wb_ld,
    input  logic [REG_AW-1:0]   wb_addr,
    input  logic [DATA_W-1:0]   wb_data,
    input  logic [TAG_W-1:0]    wb_tag,
    input  logic                wb_seg_ld,
    input  logic [REG_AW-1:0]   wb_seg_addr,
    input  logic [SEG_W-1:0]    wb_seg_data,
    output logic                valid_out,
    output logic                stall,
    output logic [TAG_W-1:0]    inst_tag,
    output logic [DATA_W-1:0]   reg1,
    output logic [DATA_W-1:0]   reg2,
    output logic [DATA_W-1:0]   reg3,
    output logic [DATA_W-1:0]   reg4,
    output logic                busy1,
    output logic                busy2,
    output logic                busy3,
    output logic                busy4,
    output logic [SEG_W-1:0]    seg1,
    output logic [SEG_W-1:0]    seg2,
    output logic [DATA_W-1:0]   mem_addr1,
    output logic [DATA_W-1:0]   mem_addr1_end,
    output logic [DATA_W-1:0]   mem_addr2,
    output logic [DATA_W-1:0]   mem_addr2_end,
    output logic [DATA_W-1:0]   rep_num
);

    logic [DATA_W-1:0] addr_reg2;
    logic [DATA_W-1:0] addr_reg3;
    logic [DATA_W-1:0] addr_reg4;

    wb_if wbus ();

    assign wbus.wb_ld       = wb_ld;
    assign wbus.wb_addr     = wb_addr;
    assign wbus.wb_data     = wb_data;
    assign wbus.wb_tag      = wb_tag;
    assign wbus.wb_seg_ld   = wb_seg_ld;
    assign wbus.wb_seg_addr = wb_seg_addr;
    assign wbus.wb_seg_data = wb_seg_data;

    // an instruction issues exactly when valid_out is high
    regfile rf (
        .clk        (clk),
        .rst        (rst),
        .wb         (wbus.reg_sink),
        .rd_addr1   (reg_addr1),
        .rd_addr2   (reg_addr2),
        .rd_addr3   (reg_addr3),
        .rd_addr4   (reg_addr4),
        .opsize     (opsize),
        .issue      (valid_out),
        .issue_tag  (inst_tag),
        .dest_en    (dest_en),
        .dest_reg   (dest_reg),
        .rd_data1   (reg1),
        .rd_data2   (reg2),
        .rd_data3   (reg3),
        .rd_data4   (reg4),
        .addr_data2 (addr_reg2),
        .addr_data3 (addr_reg3),
        .addr_data4 (addr_reg4),
        .busy1      (busy1),
        .busy2      (busy2),
        .busy3      (busy3),
        .busy4      (busy4)
    );

    segfile sf (
        .clk      (clk),
        .rst      (rst),
        .wb       (wbus.seg_sink),
        .rd_addr1 (seg_addr1),
        .rd_addr2 (seg_addr2),
        .base1    (seg1),
        .base2    (seg2)
    );

    issue_ctrl ic (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .fwd_stall (fwd_stall),
        .usereg2   (usereg2),
        .usereg3   (usereg3),
        .mem1_use  (mem1_use),
        .mem2_use  (mem2_use),
        .busy2     (busy2),
        .busy3     (busy3),
        .busy4     (busy4),
        .dest_en   (dest_en),
        .stall     (stall),
        .valid_out (valid_out),
        .tag       (inst_tag)
    );

    agen ag (
        .base_reg      (addr_reg2),
        .index_reg     (addr_reg3),
        .mem2_reg      (addr_reg4),
        .shf_amnt      (shf_amnt),
        .disp          (disp),
        .usereg2       (usereg2),
        .usereg3       (usereg3),
        .seg_base1     (seg1),
        .seg_base2     (seg2),
        .opsize        (opsize),
        .is_rep        (is_rep),
        .mem_addr1     (mem_addr1),
        .mem_addr1_end (mem_addr1_end),
        .mem_addr2     (mem_addr2),
        .mem_addr2_end (mem_addr2_end),
        .rep_num       (rep_num)
    );

endmodule

/* design/agen.sv */
`timescale 1ns/10ps

module agen import rrag_pkg::*; (
    input  logic [DATA_W-1:0]  base_reg,
    input  logic [DATA_W-1:0]  index_reg,
    input  logic [DATA_W-1:0]  mem2_reg,
    input  logic [1:0]         shf_amnt,
    input  logic [DATA_W-1:0]  disp,
    input  logic               usereg2,
    input  logic               usereg3,
    input  logic [SEG_W-1:0]   seg_base1,
    input  logic [SEG_W-1:0]   seg_base2,
    input  opsize_t            opsize,
    input  logic               is_rep,
    output logic [DATA_W-1:0]  mem_addr1,
    output logic [DATA_W-1:0]  mem_addr1_end,
    output logic [DATA_W-1:0]  mem_addr2,
    output logic [DATA_W-1:0]  mem_addr2_end,
    output logic [DATA_W-1:0]  rep_num
);

    logic [DATA_W-1:0] base_term;
    logic [DATA_W-1:0] index_term;
    logic [DATA_W-1:0] seg1_lin;
    logic [DATA_W-1:0] seg2_lin;
    logic [DATA_W-1:0] span;

    assign base_term  = usereg2 ? base_reg : '0;
    // scaled index, scale of 1, 2, 4 or 8
    assign index_term = usereg3 ? (index_reg << shf_amnt) : '0;

    assign seg1_lin = {seg_base1, {(DATA_W - SEG_W){1'b0}}};
    assign seg2_lin = {seg_base2, {(DATA_W - SEG_W){1'b0}}};

    assign mem_addr1 = base_term + index_term + disp + seg1_lin;
    assign mem_addr2 = mem2_reg + seg2_lin;

    // last byte touched, this is what a limit check would compare
    assign span          = DATA_W'(size_bytes(opsize)) - 32'd1;
    assign mem_addr1_end = mem_addr1 + span;
    assign mem_addr2_end = mem_addr2 + span;

    // string ops take their count from the second memory register
    assign rep_num = is_rep ? mem2_reg : '0;

endmodule

/* design/issue_ctrl.sv */
`timescale 1ns/10ps

module issue_ctrl import rrag_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid_in,
    input  logic              fwd_stall,
    input  logic              usereg2,
    input  logic              usereg3,
    input  logic              mem1_use,
    input  logic              mem2_use,
    input  logic              busy2,
    input  logic              busy3,
    input  logic              busy4,
    input  logic              dest_en,
    output logic              stall,
    output logic              valid_out,
    output logic [TAG_W-1:0]  tag
);

    logic mem1_stall;
    logic mem2_stall;

    // base or index of the first operand still waiting on a writer
    assign mem1_stall = mem1_use && ((usereg2 && busy2) || (usereg3 && busy3));
    assign mem2_stall = mem2_use && busy4;

    assign stall     = fwd_stall || mem1_stall || mem2_stall;
    assign valid_out = valid_in && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            tag <= '0;
        end else if (valid_out && dest_en) begin
            tag <= tag + 1'b1;
        end
    end

endmodule

/* segfile/segfile.sv */
`timescale 1ns/10ps

module segfile import rrag_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    wb_if.seg_sink              wb,
    input  logic [REG_AW-1:0]   rd_addr1,
    input  logic [REG_AW-1:0]   rd_addr2,
    output logic [SEG_W-1:0]    base1,
    output logic [SEG_W-1:0]    base2
);

    logic [SEG_W-1:0] bases [NUM_REGS];

    // segment writes land directly, nothing tracks them as pending
    always_ff @(posedge clk) begin
        if (rst) begin
            bases <= '{default: '0};
        end else if (wb.wb_seg_ld) begin
            bases[wb.wb_seg_addr] <= wb.wb_seg_data;
        end
    end

    // new base shows up the cycle after the write
    assign base1 = bases[rd_addr1];
    assign base2 = bases[rd_addr2];

endmodule

/* regfile/regfile.sv */
`timescale 1ns/10ps

module regfile import rrag_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    wb_if.reg_sink              wb,
    input  logic [REG_AW-1:0]   rd_addr1,
    input  logic [REG_AW-1:0]   rd_addr2,
    input  logic [REG_AW-1:0]   rd_addr3,
    input  logic [REG_AW-1:0]   rd_addr4,
    input  opsize_t             opsize,
    input  logic                issue,
    input  logic [TAG_W-1:0]    issue_tag,
    input  logic                dest_en,
    input  logic [REG_AW-1:0]   dest_reg,
    output logic [DATA_W-1:0]   rd_data1,
    output logic [DATA_W-1:0]   rd_data2,
    output logic [DATA_W-1:0]   rd_data3,
    output logic [DATA_W-1:0]   rd_data4,
    output logic [DATA_W-1:0]   addr_data2,
    output logic [DATA_W-1:0]   addr_data3,
    output logic [DATA_W-1:0]   addr_data4,
    output logic                busy1,
    output logic                busy2,
    output logic                busy3,
    output logic                busy4
);

    logic [DATA_W-1:0]   regs [NUM_REGS];
    logic [NUM_REGS-1:0] pending;
    logic [TAG_W-1:0]    owner [NUM_REGS];
    logic [DATA_W-1:0]   rd_mask;
    logic                wb_retire;

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (wb.wb_ld) begin
            regs[wb.wb_addr] <= wb.wb_data;
        end
    end

    // only the most recent writer of a register may retire its mark
    assign wb_retire = wb.wb_ld && (owner[wb.wb_addr] == wb.wb_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            owner   <= '{default: '0};
        end else begin
            if (wb_retire) begin
                pending[wb.wb_addr] <= 1'b0;
            end
            // a new mark on the same register overrides the clear above
            if (issue && dest_en) begin
                pending[dest_reg] <= 1'b1;
                owner[dest_reg]   <= issue_tag;
            end
        end
    end

    assign rd_mask = size_mask(opsize);

    assign rd_data1 = regs[rd_addr1] & rd_mask;
    assign rd_data2 = regs[rd_addr2] & rd_mask;
    assign rd_data3 = regs[rd_addr3] & rd_mask;
    assign rd_data4 = regs[rd_addr4] & rd_mask;

    // address operands always use the full register
    assign addr_data2 = regs[rd_addr2];
    assign addr_data3 = regs[rd_addr3];
    assign addr_data4 = regs[rd_addr4];

    assign busy1 = pending[rd_addr1];
    assign busy2 = pending[rd_addr2];
    assign busy3 = pending[rd_addr3];
    assign busy4 = pending[rd_addr4];

endmodule

/* common/wb_if.sv */
`timescale 1ns/10ps

interface wb_if import rrag_pkg::*; ();

    // register writeback
    logic                wb_ld;
    logic [REG_AW-1:0]   wb_addr;
    logic [DATA_W-1:0]   wb_data;
    logic [TAG_W-1:0]    wb_tag;

    // segment base writeback, no tag
    logic                wb_seg_ld;
    logic [REG_AW-1:0]   wb_seg_addr;
    logic [SEG_W-1:0]    wb_seg_data;

    modport reg_sink (
        input wb_ld,
        input wb_addr,
        input wb_data,
        input wb_tag
    );

    modport seg_sink (
        input wb_seg_ld,
        input wb_seg_addr,
        input wb_seg_data
    );

endinterface

/* common/rrag_pkg.sv */
package rrag_pkg;

    localparam int NUM_REGS = 8;
    localparam int REG_AW   = 3;
    localparam int DATA_W   = 32;
    localparam int SEG_W    = 16;
    // tag wraps modulo 2**TAG_W
    localparam int TAG_W    = 3;

    // code 3 is not named and decodes as dword
    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_WORD  = 2'd1,
        SZ_DWORD = 2'd2
    } opsize_t;

    // low bits kept on a sized register read
    function automatic logic [DATA_W-1:0] size_mask(opsize_t sz);
        logic [DATA_W-1:0] mask;
        case (sz)
            SZ_BYTE: begin
                mask = 32'h0000_00ff;
            end
            SZ_WORD: begin
                mask = 32'h0000_ffff;
            end
            default: begin
                mask = 32'hffff_ffff;
            end
        endcase
        return mask;
    endfunction

    // operand length in bytes
    function automatic logic [2:0] size_bytes(opsize_t sz);
        logic [2:0] n;
        case (sz)
            SZ_BYTE: begin
                n = 3'd1;
            end
            SZ_WORD: begin
                n = 3'd2;
            end
            default: begin
                n = 3'd4;
            end
        endcase
        return n;
    endfunction

endpackage
